//--- design/vrc6_config.svh
// ###################################################################
// VRC6 sound block build constants
// widths, register base addresses, prescaler reloads, saw step count
// ###################################################################

`ifndef VRC6_CONFIG_SVH
`define VRC6_CONFIG_SVH

// cpu bus
`define VRC6_ADDR_W 16
`define VRC6_DATA_W 8

// channel settings
`define VRC6_FREQ_W     12  // pulse and saw period
`define VRC6_VOL_W      4   // pulse volume
`define VRC6_SAW_RATE_W 6   // saw accumulator rate

// raw mix, 15 + 15 + 31 = 61 max
`define VRC6_LEVEL_W 6

// saw adds per ramp, the next expiry clears the accumulator
`define VRC6_SAW_STEPS 6

// scanline prescaler reloads, count down to zero inclusive
// so 113 gives a 114 tick line and 112 a 113 tick line
`define VRC6_PRESCALE_LONG  113
`define VRC6_PRESCALE_SHORT 112

// register bases, only A15..A12 and A1..A0 are decoded
`define VRC6_A_PULSE1 16'h9000
`define VRC6_A_PULSE2 16'hA000
`define VRC6_A_SAW    16'hB000
`define VRC6_A_IRQ    16'hF000

`endif

//--- design/vrc6_reg_pkg.sv
// ###################################################################
// register side types: cpu address and data, channel settings,
// IRQ latch and counter
// ###################################################################

`include "vrc6_config.svh"

package vrc6_reg_pkg;

    // cpu bus
    typedef logic [`VRC6_ADDR_W-1:0] cpu_addr_t;
    typedef logic [`VRC6_DATA_W-1:0] cpu_data_t;

    // channel settings written by the cpu
    typedef logic [`VRC6_FREQ_W-1:0]     period_t;
    typedef logic [`VRC6_VOL_W-1:0]      pulse_vol_t;
    typedef logic [`VRC6_SAW_RATE_W-1:0] saw_rate_t;

    // irq latch and up counter, wraps at 255
    typedef logic [7:0] irq_count_t;

endpackage

//--- design/vrc6_audio_pkg.sv
// ###################################################################
// audio side types: duty, step counters, saw accumulator, mix level
// ###################################################################

`include "vrc6_config.svh"

package vrc6_audio_pkg;

    // pulse
    typedef logic [2:0] duty_t;        // high while step <= duty
    typedef logic [3:0] pulse_step_t;  // 16 steps per pulse cycle

    // saw
    typedef logic [2:0] saw_step_t;    // 0..6, adds then clear
    typedef logic [7:0] saw_acc_t;
    typedef logic [4:0] saw_out_t;     // top 5 bits of the accumulator

    // registered sum of the three channels
    typedef logic [`VRC6_LEVEL_W-1:0] mix_level_t;

endpackage

//--- design/vrc6_ifs.sv
// ###################################################################
// vrc6_pulse_if  pulse channel settings, register file to channel
// vrc6_irq_if    IRQ register write strobes and data
// ###################################################################

interface vrc6_pulse_if;
    import vrc6_reg_pkg::*;
    import vrc6_audio_pkg::*;

    logic       mode;    // digital mode, output volume constantly
    duty_t      duty;
    pulse_vol_t vol;
    period_t    period;
    logic       enable;

    modport regs (output mode, duty, vol, period, enable);
    modport chan (input  mode, duty, vol, period, enable);
endinterface

interface vrc6_irq_if;
    import vrc6_reg_pkg::*;

    // single clk20 strobes, already qualified by ce and wr
    logic      latch_lo_wr;  // latch low nibble
    logic      latch_hi_wr;  // latch high nibble
    logic      latch_wr;     // full latch byte, $F000
    logic      ctrl_wr;      // $F001
    logic      ack_wr;       // $F002
    cpu_data_t wdata;

    modport regs  (output latch_lo_wr, latch_hi_wr, latch_wr, ctrl_wr, ack_wr, wdata);
    modport timer (input  latch_lo_wr, latch_hi_wr, latch_wr, ctrl_wr, ack_wr, wdata);
endinterface

//--- design/vrc6_reg_file.sv
// ###################################################################
// VRC6 register file: board variant address swap, write decode,
// pulse and saw setting registers, IRQ write strobes
// ###################################################################

`include "vrc6_config.svh"

module vrc6_reg_file (
    input  logic                    clk20,
    input  logic                    reset,
    input  logic                    ce,
    input  logic                    wr,
    input  vrc6_reg_pkg::cpu_addr_t addr,
    input  vrc6_reg_pkg::cpu_data_t data,
    input  logic                    addr_swap,
    vrc6_pulse_if.regs              pulse1,
    vrc6_pulse_if.regs              pulse2,
    vrc6_irq_if.regs                irq_bus,
    output vrc6_reg_pkg::saw_rate_t saw_rate,
    output vrc6_reg_pkg::period_t   saw_period,
    output logic                    saw_enable
);
    import vrc6_reg_pkg::*;
    import vrc6_audio_pkg::*;

    localparam cpu_addr_t PULSE_BASE [2] = '{`VRC6_A_PULSE1, `VRC6_A_PULSE2};

    cpu_addr_t  ain;
    logic       wr_en;
    logic       p_mode   [2];
    duty_t      p_duty   [2];
    pulse_vol_t p_vol    [2];
    period_t    p_period [2];
    logic [1:0] p_enable;

    // A0/A1 exchanged on the swapped board variant
    assign ain   = addr_swap ? {addr[15:2], addr[0], addr[1]} : addr;
    assign wr_en = ce & wr;

    function automatic logic reg_hit(input cpu_addr_t base, input logic [1:0] sub);
        return {ain[15:12], ain[1:0]} == {base[15:12], sub};
    endfunction

    // channel settings, x000 / x001 / x002
    always_ff @(posedge clk20) begin
        if (wr_en) begin
            for (int ch = 0; ch < 2; ch++) begin
                if (reg_hit(PULSE_BASE[ch], 2'd0))
                    {p_mode[ch], p_duty[ch], p_vol[ch]} <= data;
                if (reg_hit(PULSE_BASE[ch], 2'd1))
                    p_period[ch][7:0] <= data;
                if (reg_hit(PULSE_BASE[ch], 2'd2))
                    p_period[ch][11:8] <= data[3:0];
            end
            if (reg_hit(`VRC6_A_SAW, 2'd0))
                saw_rate <= data[5:0];
            if (reg_hit(`VRC6_A_SAW, 2'd1))
                saw_period[7:0] <= data;
            if (reg_hit(`VRC6_A_SAW, 2'd2))
                saw_period[11:8] <= data[3:0];
        end
    end

    // enables sit in bit 7 of the x002 registers
    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            p_enable   <= 2'b00;
            saw_enable <= 1'b0;
        end else if (wr_en) begin
            for (int ch = 0; ch < 2; ch++) begin
                if (reg_hit(PULSE_BASE[ch], 2'd2))
                    p_enable[ch] <= data[7];
            end
            if (reg_hit(`VRC6_A_SAW, 2'd2))
                saw_enable <= data[7];
        end
    end

    assign pulse1.mode   = p_mode[0];
    assign pulse1.duty   = p_duty[0];
    assign pulse1.vol    = p_vol[0];
    assign pulse1.period = p_period[0];
    assign pulse1.enable = p_enable[0];

    assign pulse2.mode   = p_mode[1];
    assign pulse2.duty   = p_duty[1];
    assign pulse2.vol    = p_vol[1];
    assign pulse2.period = p_period[1];
    assign pulse2.enable = p_enable[1];

    // irq registers, decoded here and stored in the timer
    assign irq_bus.latch_wr    = wr_en & reg_hit(`VRC6_A_IRQ, 2'd0);
    assign irq_bus.ctrl_wr     = wr_en & reg_hit(`VRC6_A_IRQ, 2'd1);
    assign irq_bus.ack_wr      = wr_en & reg_hit(`VRC6_A_IRQ, 2'd2);
    assign irq_bus.latch_lo_wr = 1'b0;  // nibble latch writes are a VRC4 feature
    assign irq_bus.latch_hi_wr = 1'b0;
    assign irq_bus.wdata       = data;

endmodule

//--- design/vrc6_pulse.sv
// ###################################################################
// VRC6 pulse channel: period divider, 16 step duty counter,
// volume gating by duty, digital mode and enable
// ###################################################################

module vrc6_pulse (
    input  logic                     clk20,
    input  logic                     reset,
    input  logic                     ce,
    vrc6_pulse_if.chan               cfg,
    output vrc6_reg_pkg::pulse_vol_t sample
);
    import vrc6_reg_pkg::*;
    import vrc6_audio_pkg::*;

    period_t     div;
    pulse_step_t step;
    logic        duty_on;

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            div  <= '0;
            step <= '0;
        end else if (!cfg.enable) begin
            // held at the start of a cycle while off
            div  <= cfg.period;
            step <= '0;
        end else if (ce) begin
            if (div != '0) begin
                div <= div - 1'b1;
            end else begin
                div  <= cfg.period;
                step <= step + 1'b1;  // wraps after 16 steps
            end
        end
    end

    // duty+1 of the 16 steps are high
    assign duty_on = step <= pulse_step_t'(cfg.duty);

    assign sample = (cfg.enable && (cfg.mode || duty_on)) ? cfg.vol : '0;

endmodule

//--- design/vrc6_saw.sv
// ###################################################################
// VRC6 sawtooth channel: doubled period divider, step count,
// 8 bit accumulator, top 5 bits out
// ###################################################################

`include "vrc6_config.svh"

module vrc6_saw (
    input  logic                      clk20,
    input  logic                      reset,
    input  logic                      ce,
    input  vrc6_reg_pkg::saw_rate_t   rate,
    input  vrc6_reg_pkg::period_t     period,
    input  logic                      enable,
    output vrc6_audio_pkg::saw_out_t  sample
);
    import vrc6_reg_pkg::*;
    import vrc6_audio_pkg::*;

    logic [`VRC6_FREQ_W:0] div;    // one bit wider, reload is 2*period+1
    saw_step_t             step;
    saw_acc_t              acc;

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            div  <= '0;
            step <= '0;
            acc  <= '0;
        end else if (!enable) begin
            div  <= {period, 1'b1};
            step <= '0;
            acc  <= '0;
        end else if (ce) begin
            if (div != '0) begin
                div <= div - 1'b1;
            end else begin
                div <= {period, 1'b1};
                if (step == saw_step_t'(`VRC6_SAW_STEPS)) begin
                    // seventh expiry ends the ramp
                    step <= '0;
                    acc  <= '0;
                end else begin
                    step <= step + 1'b1;
                    acc  <= acc + saw_acc_t'(rate);  // wraps for rates above 42
                end
            end
        end
    end

    assign sample = enable ? acc[7:3] : '0;

endmodule

//--- design/vrc6_irq.sv
// ###################################################################
// VRC6 IRQ timer: latch, mode and enable flags, scanline prescaler
// with 114/114/113 tick pattern, 8 bit up counter, IRQ flag
// ###################################################################

`include "vrc6_config.svh"

module vrc6_irq (
    input  logic       clk20,
    input  logic       reset,
    input  logic       ce,
    vrc6_irq_if.timer  bus,
    output logic       irq
);
    import vrc6_reg_pkg::*;

    typedef enum logic [1:0] {
        LINE_0,
        LINE_1,
        LINE_2
    } line_e;

    localparam logic [6:0] PRE_LONG  = 7'(`VRC6_PRESCALE_LONG);
    localparam logic [6:0] PRE_SHORT = 7'(`VRC6_PRESCALE_SHORT);

    irq_count_t latch;
    irq_count_t count;
    logic       mode_cycle;   // M, count every ce instead of every scanline
    logic       irq_en;       // E
    logic       irq_en_ack;   // A, copied into E on acknowledge
    logic [6:0] prescale;
    line_e      line;
    line_e      line_next;
    logic       scan_tick;
    logic       count_tick;
    logic       load_count;

    always_ff @(posedge clk20) begin
        if (bus.latch_wr) begin
            latch <= bus.wdata;
        end else begin
            if (bus.latch_lo_wr)
                latch[3:0] <= bus.wdata[3:0];
            if (bus.latch_hi_wr)
                latch[7:4] <= bus.wdata[3:0];
        end
    end

    // control register is {M, E, A} in bits 2:0
    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            mode_cycle <= 1'b0;
            irq_en     <= 1'b0;
            irq_en_ack <= 1'b0;
        end else if (bus.ctrl_wr) begin
            {mode_cycle, irq_en, irq_en_ack} <= bus.wdata[2:0];
        end else if (bus.ack_wr) begin
            irq_en <= irq_en_ack;
        end
    end

    assign load_count = bus.ctrl_wr & bus.wdata[1];
    assign scan_tick  = prescale == '0;
    assign count_tick = ce & irq_en & (mode_cycle | scan_tick);

    always_comb begin
        case (line)
            LINE_0:  line_next = LINE_1;
            LINE_1:  line_next = LINE_2;
            default: line_next = LINE_0;
        endcase
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            prescale <= PRE_LONG;
            line     <= LINE_0;
            count    <= '0;
        end else if (load_count) begin
            prescale <= PRE_LONG;
            line     <= LINE_0;
            count    <= latch;
        end else if (ce && irq_en) begin
            if (!scan_tick) begin
                prescale <= prescale - 1'b1;
            end else begin
                line     <= line_next;
                prescale <= (line_next == LINE_2) ? PRE_SHORT : PRE_LONG;  // short third line
            end
            if (count_tick)
                count <= (count == 8'hFF) ? latch : count + 1'b1;
        end
    end

    // flag set on the wrap, any ctrl or ack write clears it
    always_ff @(posedge clk20 or posedge reset) begin
        if (reset)
            irq <= 1'b0;
        else if (bus.ctrl_wr || bus.ack_wr)
            irq <= 1'b0;
        else if (count_tick && count == 8'hFF)
            irq <= 1'b1;
    end

endmodule

//--- design/vrc6_sound_top.sv
// ###################################################################
// VRC6 sound and IRQ top: register file, two pulses, saw, IRQ timer
// and the registered raw mixer
// ###################################################################

module vrc6_sound_top (
    input  logic                       clk20,
    input  logic                       reset,
    input  logic                       ce,
    input  logic                       wr,
    input  vrc6_reg_pkg::cpu_addr_t    addr,
    input  vrc6_reg_pkg::cpu_data_t    data,
    input  logic                       addr_swap,
    output logic                       irq,
    output vrc6_audio_pkg::mix_level_t level
);
    import vrc6_reg_pkg::*;
    import vrc6_audio_pkg::*;

    saw_rate_t  saw_rate;
    period_t    saw_period;
    logic       saw_enable;
    pulse_vol_t pulse1_sample;
    pulse_vol_t pulse2_sample;
    saw_out_t   saw_sample;

    vrc6_pulse_if pulse1_bus ();
    vrc6_pulse_if pulse2_bus ();
    vrc6_irq_if   irq_bus ();

    vrc6_reg_file u_reg_file (
        .clk20      (clk20),
        .reset      (reset),
        .ce         (ce),
        .wr         (wr),
        .addr       (addr),
        .data       (data),
        .addr_swap  (addr_swap),
        .pulse1     (pulse1_bus.regs),
        .pulse2     (pulse2_bus.regs),
        .irq_bus    (irq_bus.regs),
        .saw_rate   (saw_rate),
        .saw_period (saw_period),
        .saw_enable (saw_enable)
    );

    vrc6_pulse u_pulse1 (
        .clk20  (clk20),
        .reset  (reset),
        .ce     (ce),
        .cfg    (pulse1_bus.chan),
        .sample (pulse1_sample)
    );

    vrc6_pulse u_pulse2 (
        .clk20  (clk20),
        .reset  (reset),
        .ce     (ce),
        .cfg    (pulse2_bus.chan),
        .sample (pulse2_sample)
    );

    vrc6_saw u_saw (
        .clk20  (clk20),
        .reset  (reset),
        .ce     (ce),
        .rate   (saw_rate),
        .period (saw_period),
        .enable (saw_enable),
        .sample (saw_sample)
    );

    vrc6_irq u_irq (
        .clk20 (clk20),
        .reset (reset),
        .ce    (ce),
        .bus   (irq_bus.timer),
        .irq   (irq)
    );

    // raw sum, 0..61, no dac table
    always_ff @(posedge clk20 or posedge reset) begin
        if (reset)
            level <= '0;
        else
            level <= mix_level_t'(pulse1_sample) + mix_level_t'(pulse2_sample)
                   + mix_level_t'(saw_sample);
    end

endmodule

//--- tests/tb_vrc6.sv
// ###################################################################
// VRC6 sound block testbench: clock, ce strobe, table of register
// writes with checks applied in a loop, per test and total report
// ###################################################################

`include "vrc6_config.svh"

module tb_vrc6;
    import vrc6_reg_pkg::*;

    typedef enum logic [2:0] {
        CK_NONE, CK_QUIET, CK_LEVEL, CK_HIGH_COUNT,
        CK_PEAK, CK_IRQ_RISE, CK_IRQ_LOW
    } check_kind_e;

    typedef struct packed {
        logic [2:0]  test_id;
        cpu_addr_t   addr;     // already swapped when swap is set
        cpu_data_t   data;
        logic        swap;
        check_kind_e kind;
        logic [15:0] exp;      // expected value, or lower bound / tick count
        logic [15:0] exp_hi;
    } step_t;

    logic                      clk20;
    logic                      reset;
    logic                      ce;
    logic                      wr;
    cpu_addr_t                 addr;
    cpu_data_t                 data;
    logic                      addr_swap;
    logic                      irq;
    logic [`VRC6_LEVEL_W-1:0]  level;

    logic [1:0]  ce_phase;
    int unsigned lcg_state;
    step_t       steps[$];
    int          n_checks;
    int          n_errors;
    string       test_names [7] = '{"", "reset state", "digital mode mix", "duty ratio",
                                    "saw peak", "irq cycle mode", "irq scanline mode"};

    vrc6_sound_top uut (
        .clk20     (clk20),
        .reset     (reset),
        .ce        (ce),
        .wr        (wr),
        .addr      (addr),
        .data      (data),
        .addr_swap (addr_swap),
        .irq       (irq),
        .level     (level)
    );

    initial begin
        clk20 = 1'b0;
        forever #2 clk20 = ~clk20;
    end

    // ce on one clk20 edge in three
    always @(negedge clk20) begin
        if (reset) begin
            ce_phase <= 2'd0;
            ce       <= 1'b0;
        end else begin
            ce_phase <= (ce_phase == 2'd2) ? 2'd0 : ce_phase + 2'd1;
            ce       <= (ce_phase == 2'd2);
        end
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // 8 bit accumulator, six adds per ramp, output is bits 7:3
    function automatic int saw_peak(input int rate);
        int best;
        int acc;
        best = 0;
        for (int k = 1; k <= `VRC6_SAW_STEPS; k++) begin
            acc = (k * rate) % 256;
            if (acc / 8 > best)
                best = acc / 8;
        end
        return best;
    endfunction

    task automatic add_step(input int id, input cpu_addr_t a, input cpu_data_t d,
                            input logic sw, input check_kind_e k, input int e, input int e_hi);
        step_t s;
        s.test_id = 3'(id);
        s.addr    = sw ? {a[15:2], a[0], a[1]} : a;  // A0/A1 crossed on that board
        s.data    = d;
        s.swap    = sw;
        s.kind    = k;
        s.exp     = 16'(e);
        s.exp_hi  = 16'(e_hi);
        steps.push_back(s);
    endtask

    // returns at the falling edge after a ce edge
    task automatic wait_ce();
        int guard;
        guard = 0;
        do begin
            @(negedge clk20);
            guard++;
        end while (!ce && guard < 6);
        if (!ce) begin
            $display("timeout: no ce strobe seen within %0d clk20 cycles", guard);
            n_errors++;
        end
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        n_checks++;
        assert (got == expected)
        else begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            n_errors++;
        end
    endtask

    // wr held over three edges, exactly one of them carries ce
    task automatic write_reg(input cpu_addr_t a, input cpu_data_t d, input logic sw);
        @(negedge clk20);
        wr        <= 1'b1;
        addr      <= a;
        data      <= d;
        addr_swap <= sw;
        repeat (3) @(negedge clk20);
        wr <= 1'b0;
    endtask

    task automatic run_step(input step_t s);
        int count;
        int ticks;
        if (s.kind != CK_QUIET)
            write_reg(s.addr, s.data, s.swap);
        count = 0;
        ticks = 0;
        case (s.kind)
            CK_QUIET: begin
                for (int i = 0; i < int'(s.exp); i++) begin
                    @(negedge clk20);
                    if (level != '0 || irq)
                        count++;
                end
                check_value("clocks with level or irq set", count, 0);
            end
            CK_LEVEL: begin
                repeat (3) wait_ce();
                check_value("level", int'(level), int'(s.exp));
            end
            CK_HIGH_COUNT: begin
                repeat (3) wait_ce();
                for (int i = 0; i < 16 * 4; i++) begin  // one full cycle at period 3
                    wait_ce();
                    if (level != '0)
                        count++;
                end
                check_value("high samples", count, int'(s.exp));
            end
            CK_PEAK: begin
                for (int i = 0; i < 80; i++) begin
                    wait_ce();
                    if (int'(level) > count)
                        count = int'(level);
                end
                check_value("saw peak level", count, int'(s.exp));
            end
            CK_IRQ_RISE: begin
                while (!irq && ticks < int'(s.exp_hi) + 4) begin
                    wait_ce();
                    ticks++;
                end
                n_checks++;
                assert (irq)
                else begin
                    $display("timeout: irq did not rise within %0d ce ticks", ticks);
                    n_errors++;
                end
                if (irq) begin
                    n_checks++;
                    assert (ticks >= int'(s.exp) && ticks <= int'(s.exp_hi))
                    else begin
                        $display("mismatch at %0t: irq after %0d ce ticks, expected %0d to %0d",
                                 $time, ticks, s.exp, s.exp_hi);
                        n_errors++;
                    end
                end
            end
            CK_IRQ_LOW: begin
                if (irq)
                    count++;
                for (int i = 0; i < int'(s.exp); i++) begin
                    wait_ce();
                    if (irq)
                        count++;
                end
                check_value("ce ticks with irq high", count, 0);
            end
            default: ;
        endcase
    endtask

    initial begin
        int duties [3] = '{0, 3, 7};
        int rates [2] = '{42, 63};
        int v1;
        int v2;
        int err_base;
        reset     = 1'b1;
        wr        = 1'b0;
        addr      = '0;
        data      = '0;
        addr_swap = 1'b0;
        ce        = 1'b0;
        ce_phase  = 2'd0;
        lcg_state = 44530;
        n_checks  = 0;
        n_errors  = 0;

        add_step(1, '0, '0, 1'b0, CK_QUIET, 200, 0);
        for (int sw = 0; sw < 2; sw++) begin
            v1 = 1 + int'((lcg_next() >> 16) % 15);  // nonzero volumes
            v2 = 1 + int'((lcg_next() >> 16) % 15);
            // both pulses off through the plain map first
            add_step(2, `VRC6_A_PULSE1 + 16'd2, 8'h00, 1'b0, CK_NONE, 0, 0);
            add_step(2, `VRC6_A_PULSE2 + 16'd2, 8'h00, 1'b0, CK_NONE, 0, 0);
            add_step(2, `VRC6_A_SAW + 16'd2, 8'h00, sw[0], CK_NONE, 0, 0);
            add_step(2, `VRC6_A_PULSE1 + 16'd2, 8'h80, sw[0], CK_NONE, 0, 0);
            add_step(2, `VRC6_A_PULSE2 + 16'd2, 8'h80, sw[0], CK_NONE, 0, 0);
            add_step(2, `VRC6_A_PULSE1, {4'h8, v1[3:0]}, sw[0], CK_NONE, 0, 0);
            add_step(2, `VRC6_A_PULSE2, {4'h8, v2[3:0]}, sw[0], CK_LEVEL, v1 + v2, 0);
        end
        add_step(3, `VRC6_A_PULSE2 + 16'd2, 8'h00, 1'b0, CK_NONE, 0, 0);
        add_step(3, `VRC6_A_PULSE1 + 16'd1, 8'h03, 1'b0, CK_NONE, 0, 0);
        add_step(3, `VRC6_A_PULSE1 + 16'd2, 8'h80, 1'b0, CK_NONE, 0, 0);
        foreach (duties[i])
            add_step(3, `VRC6_A_PULSE1, {1'b0, 3'(duties[i]), 4'hF}, 1'b0, CK_HIGH_COUNT,
                     (duties[i] + 1) * 4, 0);
        add_step(4, `VRC6_A_PULSE1 + 16'd2, 8'h00, 1'b0, CK_NONE, 0, 0);
        foreach (rates[i]) begin
            add_step(4, `VRC6_A_SAW + 16'd2, 8'h00, 1'b0, CK_NONE, 0, 0);
            add_step(4, `VRC6_A_SAW, 8'(rates[i]), 1'b0, CK_NONE, 0, 0);
            add_step(4, `VRC6_A_SAW + 16'd1, 8'h01, 1'b0, CK_NONE, 0, 0);
            add_step(4, `VRC6_A_SAW + 16'd2, 8'h80, 1'b0, CK_PEAK, saw_peak(rates[i]), 0);
        end
        add_step(5, `VRC6_A_IRQ, 8'd250, 1'b0, CK_NONE, 0, 0);
        add_step(5, `VRC6_A_IRQ + 16'd1, 8'h06, 1'b0, CK_IRQ_RISE, 5, 7);  // M=1 E=1
        add_step(5, `VRC6_A_IRQ + 16'd2, 8'h00, 1'b0, CK_IRQ_LOW, 40, 0);
        add_step(6, `VRC6_A_IRQ, 8'd254, 1'b0, CK_NONE, 0, 0);
        add_step(6, `VRC6_A_IRQ + 16'd1, 8'h02, 1'b0, CK_IRQ_RISE, 2 * 113, 2 * 115);
        add_step(6, `VRC6_A_IRQ + 16'd1, 8'h00, 1'b0, CK_IRQ_LOW, 40, 0);

        repeat (2) @(negedge clk20);
        reset <= 1'b0;

        err_base = 0;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].test_id != steps[i].test_id) begin
                $display("test %0d %s: %s", steps[i].test_id, test_names[steps[i].test_id],
                         (n_errors == err_base) ? "ok" : "errors");
                err_base = n_errors;
            end
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/vrc6_reg_pkg.sv
design/vrc6_audio_pkg.sv
design/vrc6_ifs.sv
design/vrc6_reg_file.sv
design/vrc6_pulse.sv
design/vrc6_saw.sv
design/vrc6_irq.sv
design/vrc6_sound_top.sv
tests/tb_vrc6.sv

//--- run.sh
#!/bin/sh
# build and run the VRC6 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vrc6 \
    -f src.f --Mdir obj_dir -o sim_vrc6 > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_vrc6 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0
